/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= exec_cluster_tb
FILELIST  ?= list.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/alu_lane.sv */
`default_nettype none
`timescale 1ns/100ps

module alu_lane
    import pipe_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       flush,
    input  wire logic       ex_valid,
    input  wire logic       ex_ready,
    input  wire exec_slot_t slot,
    output commit_t         result
);

    word_t            op_a;
    word_t            op_b;
    word_t            alu_out;
    logic [SHAMT_W-1:0] shamt;
    commit_t          next_result;

    assign op_a  = slot.rj_data;
    assign op_b  = (slot.slot.uop == UOP_ADDI || slot.slot.uop == UOP_LUI) ?
                   slot.slot.imm : slot.rk_data;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (slot.slot.uop)
            UOP_ADD,
            UOP_ADDI: alu_out = op_a + op_b;
            UOP_SUB:  alu_out = op_a - op_b;
            UOP_AND:  alu_out = op_a & op_b;
            UOP_OR:   alu_out = op_a | op_b;
            UOP_XOR:  alu_out = op_a ^ op_b;
            UOP_SLL:  alu_out = op_a << shamt;
            UOP_SRL:  alu_out = op_a >> shamt;
            UOP_SLT:  alu_out = word_t'($signed(op_a) < $signed(op_b));
            UOP_LUI:  alu_out = op_b;
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        next_result.valid      = ex_valid;
        next_result.pc         = slot.slot.pc;
        next_result.rd         = slot.slot.rd;
        next_result.data       = alu_out;
        next_result.is_syscall = slot.slot.is_syscall;
        next_result.is_break   = slot.slot.is_break;
        // Exceptions and x0 never write.
        next_result.we         = ex_valid && slot.slot.is_alu && slot.slot.rd != '0 &&
                                 !slot.slot.is_syscall && !slot.slot.is_break;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            result <= '0;
        end else if (ex_ready) begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

/* design/exec_cluster_top.sv */
`default_nettype none
`timescale 1ns/100ps

module exec_cluster_top
    import pipe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        issue_valid,
    output logic             issue_ready,
    input  wire issue_slot_t issue_bundle [NUM_LANES],
    input  wire logic        flush,
    input  wire logic        commit_ready,
    output commit_t          commit [NUM_LANES]
);

    logic       ex_ready;
    logic       ex_valid;
    exec_slot_t ex_bundle   [NUM_LANES];
    commit_t    lane_result [NUM_LANES];
    reg_idx_t   rf_raddr    [NUM_READ_PORTS];
    word_t      rf_rdata    [NUM_READ_PORTS];
    logic       rf_we       [NUM_LANES];
    reg_idx_t   rf_waddr    [NUM_LANES];
    word_t      rf_wdata    [NUM_LANES];

    assign ex_ready = commit_ready;  // Lanes are single cycle.

    reg_read_stage rr_i (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_bundle (issue_bundle),
        .ex_ready     (ex_ready),
        .ex_valid     (ex_valid),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata),
        .ex_bundle    (ex_bundle)
    );

    regfile_4r2w rf_i (
        .clk   (clk),
        .rst   (rst),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr (rf_raddr),
        .rdata (rf_rdata)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : lane_g
        alu_lane lane_i (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .ex_valid (ex_valid),
            .ex_ready (ex_ready),
            .slot     (ex_bundle[i]),
            .result   (lane_result[i])
        );
    end

    writeback_arbiter wb_i (
        .clk         (clk),
        .rst         (rst),
        .ex_ready    (ex_ready),
        .lane_result (lane_result),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .commit      (commit)
    );

endmodule

`default_nettype wire

/* design/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    localparam int NUM_LANES      = 2;
    localparam int XLEN           = 32;
    localparam int NUM_REGS       = 32;
    localparam int REG_IDX_W      = $clog2(NUM_REGS);
    localparam int NUM_READ_PORTS = 2 * NUM_LANES;  // rj and rk per lane.
    localparam int UOP_W          = 4;
    localparam int SHAMT_W        = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [UOP_W-1:0] {
        UOP_NOP  = 4'd0,
        UOP_ADD  = 4'd1,
        UOP_SUB  = 4'd2,
        UOP_AND  = 4'd3,
        UOP_OR   = 4'd4,
        UOP_XOR  = 4'd5,
        UOP_SLL  = 4'd6,
        UOP_SRL  = 4'd7,
        UOP_SLT  = 4'd8,
        UOP_ADDI = 4'd9,
        UOP_LUI  = 4'd10
    } uop_e;

    // Decoded instruction as it leaves the decode stage.
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        logic     is_alu;
        logic     is_syscall;
        logic     is_break;
        uop_e     uop;
        word_t    imm;       // Already shifted for LUI.
        reg_idx_t rj;
        reg_idx_t rk;
        reg_idx_t rd;
    } issue_slot_t;

    typedef struct packed {
        issue_slot_t slot;
        word_t       rj_data;
        word_t       rk_data;
    } exec_slot_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     we;
        word_t    data;
        logic     is_syscall;
        logic     is_break;
    } commit_t;

endpackage

`default_nettype wire

/* design/reg_read_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module reg_read_stage
    import pipe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        flush,
    input  wire logic        issue_valid,
    output logic             issue_ready,
    input  wire issue_slot_t issue_bundle [NUM_LANES],
    input  wire logic        ex_ready,
    output logic             ex_valid,
    output reg_idx_t         rf_raddr [NUM_READ_PORTS],
    input  wire word_t       rf_rdata [NUM_READ_PORTS],
    output exec_slot_t       ex_bundle [NUM_LANES]
);

    logic       load;
    logic       clear;
    exec_slot_t next_slot [NUM_LANES];

    // Operand reads never stall, so the issue side follows execute.
    assign issue_ready = ex_ready;

    assign load  = issue_valid && ex_ready;
    assign clear = rst || flush || (!issue_valid && ex_ready);  // Bubble on no input.

    // Lane i reads ports 2i and 2i+1.
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rf_raddr[2*i]   = issue_bundle[i].rj;
            rf_raddr[2*i+1] = issue_bundle[i].rk;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            next_slot[i].slot    = issue_bundle[i];
            next_slot[i].rj_data = rf_rdata[2*i];
            next_slot[i].rk_data = rf_rdata[2*i+1];
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            ex_valid <= 1'b0;
        end else if (load) begin
            ex_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                ex_bundle[i] <= '0;
            end
        end else if (load) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                ex_bundle[i] <= next_slot[i];
            end
        end
    end

endmodule

`default_nettype wire

/* design/regfile_4r2w.sv */
`default_nettype none
`timescale 1ns/100ps

module regfile_4r2w
    import pipe_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     we    [NUM_LANES],
    input  wire reg_idx_t waddr [NUM_LANES],
    input  wire word_t    wdata [NUM_LANES],
    input  wire reg_idx_t raddr [NUM_READ_PORTS],
    output word_t         rdata [NUM_READ_PORTS]
);

    word_t regs [NUM_REGS];

    // Port 1 is assigned last so it wins on an equal address.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            if (we[0]) begin
                regs[waddr[0]] <= wdata[0];
            end
            if (we[1]) begin
                regs[waddr[1]] <= wdata[1];
            end
        end
    end

    // Write-through read, same priority as the write.
    always_comb begin
        for (int p = 0; p < NUM_READ_PORTS; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;  // x0 is hardwired.
            end else if (we[1] && waddr[1] == raddr[p]) begin
                rdata[p] = wdata[1];
            end else if (we[0] && waddr[0] == raddr[p]) begin
                rdata[p] = wdata[0];
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

/* design/writeback_arbiter.sv */
`default_nettype none
`timescale 1ns/100ps

module writeback_arbiter
    import pipe_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    ex_ready,
    input  wire commit_t lane_result [NUM_LANES],
    output logic         rf_we    [NUM_LANES],
    output reg_idx_t     rf_waddr [NUM_LANES],
    output word_t        rf_wdata [NUM_LANES],
    output commit_t      commit   [NUM_LANES]
);

    commit_t resolved [NUM_LANES];
    logic    same_rd;

    // Lane 1 is younger, so it keeps the write.
    assign same_rd = lane_result[0].we && lane_result[1].we &&
                     lane_result[0].rd == lane_result[1].rd;

    always_comb begin
        resolved[0] = lane_result[0];
        resolved[1] = lane_result[1];
        if (same_rd) begin
            resolved[0].we = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                commit[i] <= '0;
            end
        end else if (ex_ready) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                commit[i] <= resolved[i];
            end
        end
    end

    // Write only on the edge where the record leaves.
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            rf_we[i]    = ex_ready && commit[i].valid && commit[i].we;
            rf_waddr[i] = commit[i].rd;
            rf_wdata[i] = commit[i].data;
        end
    end

endmodule

`default_nettype wire

/* list.f */
design/pipe_pkg.sv
design/regfile_4r2w.sv
design/reg_read_stage.sv
design/alu_lane.sv
design/writeback_arbiter.sv
design/exec_cluster_top.sv
tests/exec_cluster_checker.sv
tests/exec_cluster_tb.sv

/* tests/exec_cluster_checker.sv */
`default_nettype none
`timescale 1ns/100ps

module exec_cluster_checker
    import pipe_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        issue_valid,
    input  wire logic        issue_ready,
    input  wire logic        flush,
    input  wire logic        commit_ready,
    input  wire issue_slot_t issue_bundle [NUM_LANES],
    input  wire logic [7:0]  test_id,
    input  wire commit_t     commit [NUM_LANES],
    output logic             busy
);

    localparam int MAX_TAGS = 256;

    issue_slot_t held [MAX_TAGS][NUM_LANES];
    logic [7:0]  held_id [MAX_TAGS];
    int          commit_q [$];
    word_t       model [NUM_REGS];
    int next_tag = 0;
    int stage_tag = -1;
    int lane_tag = -1;
    int cur_test = -1;
    int test_commits = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int stray_errors = 0;

    function automatic word_t expect_data(uop_e uop, word_t a, word_t b);
        case (uop)
            UOP_ADD, UOP_ADDI: return a + b;
            UOP_SUB:  return a - b;
            UOP_AND:  return a & b;
            UOP_OR:   return a | b;
            UOP_XOR:  return a ^ b;
            UOP_SLL:  return a << b[4:0];
            UOP_SRL:  return a >> b[4:0];
            UOP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            UOP_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    task automatic compare(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (cur_test >= 0) begin
            if (test_errors == 0) begin
                $display("test %0d: %0d commits ok", cur_test, test_commits);
                tests_passed++;
            end else begin
                $display("test %0d: %0d commits, %0d errors", cur_test, test_commits,
                         test_errors);
                tests_failed++;
            end
        end
    endtask

    task automatic check_record();
        int          tag;
        word_t       a;
        word_t       b;
        commit_t     exp [NUM_LANES];
        issue_slot_t s;
        string       f;
        if (commit_q.size() == 0) begin
            $display("unexpected commit record while no accepted bundle was in flight");
            stray_errors++;
            return;
        end
        tag = commit_q.pop_front();
        if (int'(held_id[tag]) != cur_test) begin
            close_test();
            cur_test = int'(held_id[tag]);
            test_commits = 0;
            test_errors = 0;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            s = held[tag][i];
            a = model[s.rj];
            b = (s.uop == UOP_ADDI || s.uop == UOP_LUI) ? s.imm : model[s.rk];
            exp[i] = '0;
            exp[i].valid = 1'b1;
            exp[i].pc = s.pc;
            exp[i].rd = s.rd;
            exp[i].data = expect_data(s.uop, a, b);
            exp[i].is_syscall = s.is_syscall;
            exp[i].is_break = s.is_break;
            exp[i].we = s.is_alu && s.rd != 0 && !s.is_syscall && !s.is_break;
        end
        if (exp[0].we && exp[1].we && exp[0].rd == exp[1].rd) begin
            exp[0].we = 1'b0;  // Younger lane wins.
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            f = $sformatf("commit[%0d].", i);
            compare({f, "valid"}, word_t'(exp[i].valid), word_t'(commit[i].valid));
            compare({f, "pc"}, exp[i].pc, commit[i].pc);
            compare({f, "rd"}, word_t'(exp[i].rd), word_t'(commit[i].rd));
            compare({f, "we"}, word_t'(exp[i].we), word_t'(commit[i].we));
            compare({f, "data"}, exp[i].data, commit[i].data);
            compare({f, "is_syscall"}, word_t'(exp[i].is_syscall),
                    word_t'(commit[i].is_syscall));
            compare({f, "is_break"}, word_t'(exp[i].is_break), word_t'(commit[i].is_break));
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (exp[i].we) begin
                model[exp[i].rd] = exp[i].data;
            end
        end
        test_commits++;
    endtask

    // Tracks which bundle sits in the stage and lane registers.
    always @(posedge clk) begin
        if (rst) begin
            stage_tag = -1;
            lane_tag = -1;
            commit_q.delete();
            for (int r = 0; r < NUM_REGS; r++) begin
                model[r] = '0;
            end
        end else begin
            if (issue_ready !== commit_ready) begin
                $display("[ERROR] issue_ready expected %h actual %h", commit_ready, issue_ready);
                stray_errors++;
            end
            if (commit_ready && (commit[0].valid || commit[1].valid)) begin
                check_record();
            end
            if (commit_ready && lane_tag >= 0) begin
                commit_q.push_back(lane_tag);
            end
            if (flush) begin
                stage_tag = -1;
                lane_tag = -1;
            end else if (commit_ready) begin
                lane_tag = stage_tag;
                stage_tag = -1;
                if (issue_valid) begin
                    held[next_tag % MAX_TAGS] = issue_bundle;
                    held_id[next_tag % MAX_TAGS] = test_id;
                    stage_tag = next_tag % MAX_TAGS;
                    next_tag++;
                end
            end
        end
        busy <= stage_tag >= 0 || lane_tag >= 0 || commit_q.size() != 0;
    end

endmodule

`default_nettype wire

/* tests/exec_cluster_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module exec_cluster_tb
    import pipe_pkg::*;
();

    localparam int WORDS_PER_LINE = 10;
    localparam int MAX_LINES      = 64;
    localparam int ACCEPT_LIMIT   = 100;
    localparam int DRAIN_LIMIT    = 400;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue_valid;
    logic        issue_ready;
    issue_slot_t issue_bundle [NUM_LANES];
    logic        flush;
    logic        commit_ready;
    commit_t     commit [NUM_LANES];
    logic [7:0]  test_id;
    logic        chk_busy;

    word_t       td [MAX_LINES*WORDS_PER_LINE];
    logic [31:0] lfsr = 32'hd8cb0e40;
    logic        stall_b0;
    logic        stall_b1;
    logic        timed_out = 1'b0;
    int          line;
    int          waited;

    always #4 clk = ~clk;

    exec_cluster_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_bundle (issue_bundle),
        .flush        (flush),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

    exec_cluster_checker chk_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .flush        (flush),
        .commit_ready (commit_ready),
        .issue_bundle (issue_bundle),
        .test_id      (test_id),
        .commit       (commit),
        .busy         (chk_busy)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // Columns: pc, ctl (flags in the high nibble, uop in the low), imm, rj/rk/rd.
    function automatic issue_slot_t make_slot(int base);
        issue_slot_t s;
        s = '0;
        s.pc         = td[base];
        s.is_alu     = td[base+1][6];
        s.is_syscall = td[base+1][5];
        s.is_break   = td[base+1][4];
        s.uop        = uop_e'(td[base+1][3:0]);
        s.imm        = td[base+2];
        s.rj         = td[base+3][20:16];
        s.rk         = td[base+3][12:8];
        s.rd         = td[base+3][4:0];
        return s;
    endfunction

    // Low for about one cycle in four.
    always @(posedge clk) begin
        if (rst) begin
            commit_ready <= 1'b1;
        end else begin
            lfsr = lfsr_next(lfsr);
            stall_b0 = lfsr[0];
            lfsr = lfsr_next(lfsr);
            stall_b1 = lfsr[0];
            commit_ready <= !(stall_b0 && stall_b1);
        end
    end

    initial begin
        rst = 1'b1;
        issue_valid = 1'b0;
        flush = 1'b0;
        commit_ready = 1'b1;
        test_id = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            issue_bundle[i] = '0;
        end
        $readmemh("tests/exec_cluster_testdata.txt", td);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        line = 0;
        while (!timed_out && line < MAX_LINES && td[line*WORDS_PER_LINE][7:0] != 8'hff) begin
            issue_valid     <= 1'b1;
            test_id         <= td[line*WORDS_PER_LINE][7:0];
            issue_bundle[0] <= make_slot(line*WORDS_PER_LINE + 2);
            issue_bundle[1] <= make_slot(line*WORDS_PER_LINE + 6);
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!issue_ready && waited < ACCEPT_LIMIT);
            if (!issue_ready) begin
                $display("timeout: bundle on data line %0d was never accepted", line);
                timed_out = 1'b1;
            end else if (td[line*WORDS_PER_LINE+1][0]) begin
                issue_valid <= 1'b0;
                flush       <= 1'b1;  // Kills the bundle just accepted.
                @(posedge clk);
                flush       <= 1'b0;
            end
            line++;
        end
        issue_valid <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!timed_out && chk_busy && waited < DRAIN_LIMIT);
        if (!timed_out && chk_busy) begin
            $display("timeout: accepted bundles did not all commit");
            timed_out = 1'b1;
        end
        chk_i.close_test();
        $display("tests: %0d passed, %0d failed, %0d stray errors",
                 chk_i.tests_passed, chk_i.tests_failed, chk_i.stray_errors);
        if (timed_out || chk_i.tests_failed != 0 || chk_i.stray_errors != 0 ||
            chk_i.tests_passed == 0) begin
            $display("TESTS FAILED");
        end else begin
            $display("TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/exec_cluster_testdata.txt */
// test flush | lane0: pc ctl imm rj_rk_rd | lane1: pc ctl imm rj_rk_rd
// ctl high nibble: 4 alu, 2 syscall, 1 break; low nibble: uop. Test ff ends the list.
01 0 00001000 49 00007ff3 000001 00001004 4a 80000000 000002
01 0 00001008 49 fffffff0 000003 0000100c 49 00000005 000004
01 0 00001010 4a 12340000 000005 00001014 49 0f0f0f0f 000006
01 0 00001018 41 00000000 010207 0000101c 42 00000000 010208
01 0 00001020 43 00000000 030409 00001024 44 00000000 03040a
01 0 00001028 45 00000000 05060b 0000102c 46 00000000 06040c
01 0 00001030 47 00000000 03040d 00001034 48 00000000 03040e
01 0 00001038 48 00000000 04030f 0000103c 48 00000000 020110
02 0 00001040 41 00000000 070811 00001044 49 00000055 010000
02 0 00001048 41 00000000 000112 0000104c 42 00000000 090a13
02 0 00001050 45 00000000 0c0d15 00001054 44 00000000 0e0f16
02 0 00001058 41 00000000 110014 0000105c 41 00000000 001017
03 0 00001060 49 00000111 000018 00001064 49 00000222 000018
03 0 00001068 49 00000001 010019 0000106c 00 00000000 000000
03 0 00001070 00 00000000 000000 00001074 00 00000000 000000
03 0 00001078 41 00000000 18001a 0000107c 44 00000000 18181b
04 0 00001080 20 00000000 000005 00001084 51 00000000 010206
04 0 00001088 00 00000000 000000 0000108c 00 00000000 000000
04 0 00001090 41 00000000 05001c 00001094 41 00000000 06001d
05 0 00001098 00 00000000 000000 0000109c 00 00000000 000000
05 1 000010a0 49 0000dead 00001e 000010a4 00 00000000 000000
05 0 000010a8 41 00000000 1e001f 000010ac 00 00000000 000000
06 0 000010b0 42 00000000 070802 000010b4 45 00000000 090a03
06 0 000010b8 46 00000000 0b0c04 000010bc 47 00000000 100e05
06 0 000010c0 49 00000007 000007 000010c4 49 00000008 000008
06 0 000010c8 41 00000000 020306 000010cc 48 00000000 141509
06 0 000010d0 41 00000000 04050a 000010d4 00 00000000 000000
ff 0 00000000 00 00000000 000000 00000000 00 00000000 000000
